// File: src/mul_types_pkg.sv
package mul_types_pkg;

    // ####################################################################
    // request and response of the multiply unit
    // ####################################################################

    localparam int XLEN = 32;  // operand and result width.

    typedef enum logic [1:0] {
        MUL   = 2'b00,  // low word, sign does not matter.
        MULH  = 2'b01,  // high word of the signed product.
        MULHU = 2'b10   // high word of the unsigned product.
    } mul_op_t;

    typedef struct packed {
        mul_op_t         op;
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
    } mul_req_t;

    typedef struct packed {
        logic            ok;      // result is valid in this cycle only.
        logic [XLEN-1:0] result;
    } mul_rsp_t;

endpackage

// File: src/mul_arith_pkg.sv
package mul_arith_pkg;

    // ####################################################################
    // radix-4 booth recoding
    // ####################################################################

    // one recoded digit of the multiplier, taken from a 3-bit window.
    typedef enum logic [2:0] {
        BOOTH_ZERO = 3'b000,
        BOOTH_POS1 = 3'b001,
        BOOTH_POS2 = 3'b010,
        BOOTH_NEG1 = 3'b101,
        BOOTH_NEG2 = 3'b110
    } booth_digit_t;

    // ####################################################################
    // partial product count
    // ####################################################################

    // the multiplier is extended by two bits above for the unsigned case,
    // which adds one digit to the width / 2 windows of a signed operand.
    function automatic int pp_count(input int width);
        return width / 2 + 1;
    endfunction

endpackage

// File: src/booth_radix4.sv
module booth_radix4 #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]                                    x,
    input  logic [WIDTH-1:0]                                    y,
    input  logic                                                mul_signed,
    output logic [mul_arith_pkg::pp_count(WIDTH)*2*WIDTH-1:0]   pp
);

    localparam int PP = mul_arith_pkg::pp_count(WIDTH);
    localparam int P  = 2 * WIDTH;

    logic [P-1:0]     ext_x;
    logic [WIDTH+2:0] ext_y;
    logic [P-1:0]     mult_pos1;
    logic [P-1:0]     mult_pos2;
    logic [P-1:0]     mult_neg1;
    logic [P-1:0]     mult_neg2;

    // maps a window {y[2j+1], y[2j], y[2j-1]} onto its digit.
    function automatic mul_arith_pkg::booth_digit_t booth_decode(input logic [2:0] win);
        mul_arith_pkg::booth_digit_t digit;
        case (win)
            3'b001, 3'b010: digit = mul_arith_pkg::BOOTH_POS1;
            3'b011:         digit = mul_arith_pkg::BOOTH_POS2;
            3'b100:         digit = mul_arith_pkg::BOOTH_NEG2;
            3'b101, 3'b110: digit = mul_arith_pkg::BOOTH_NEG1;
            default:        digit = mul_arith_pkg::BOOTH_ZERO;
        endcase
        return digit;
    endfunction

    // ####################################################################
    // operand extension and the four nonzero multiples
    // ####################################################################

    assign ext_x = {{WIDTH{mul_signed & x[WIDTH-1]}}, x};
    assign ext_y = {{2{mul_signed & y[WIDTH-1]}}, y, 1'b0};  // zero below bit 0.

    assign mult_pos1 = ext_x;
    assign mult_pos2 = ext_x << 1;
    assign mult_neg1 = -ext_x;
    assign mult_neg2 = -(ext_x << 1);

    // ####################################################################
    // one partial product per digit
    // ####################################################################

    for (genvar j = 0; j < PP; j++) begin : g_pp
        mul_arith_pkg::booth_digit_t digit;
        logic [P-1:0]                multiple;

        assign digit = booth_decode(ext_y[2*j +: 3]);

        always_comb begin
            case (digit)
                mul_arith_pkg::BOOTH_POS1: multiple = mult_pos1;
                mul_arith_pkg::BOOTH_POS2: multiple = mult_pos2;
                mul_arith_pkg::BOOTH_NEG1: multiple = mult_neg1;
                mul_arith_pkg::BOOTH_NEG2: multiple = mult_neg2;
                default:                   multiple = '0;
            endcase
        end

        assign pp[j*P +: P] = multiple << (2 * j);  // weight of digit j is 4^j.
    end

endmodule

// File: src/wallace_tree.sv
module wallace_tree #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]   x,
    input  logic [WIDTH-1:0]   y,
    input  logic               mul_signed,
    output logic [2*WIDTH-1:0] product
);

    localparam int PP = mul_arith_pkg::pp_count(WIDTH);
    localparam int P  = 2 * WIDTH;

    // ####################################################################
    // level schedule
    // ####################################################################

    // every full group of three rows becomes a sum and a carry row, and
    // the rows left over pass straight to the next level.
    function automatic int rows_after(input int rows);
        return 2 * (rows / 3) + rows % 3;
    endfunction

    function automatic int rows_at(input int rows, input int level);
        int n;
        int i;
        n = rows;
        for (i = 0; i < level; i++) begin
            n = rows_after(n);
        end
        return n;
    endfunction

    function automatic int level_count(input int rows);
        int n;
        int levels;
        n      = rows;
        levels = 0;
        while (n > 2) begin
            n      = rows_after(n);
            levels = levels + 1;
        end
        return levels;
    endfunction

    localparam int LEVELS = level_count(PP);  // six levels for 17 rows.

    logic [PP*P-1:0] pp;
    logic [P-1:0]    row [LEVELS+1][PP];

    booth_radix4 #(
        .WIDTH (WIDTH)
    ) u_booth (
        .x          (x),
        .y          (y),
        .mul_signed (mul_signed),
        .pp         (pp)
    );

    for (genvar r = 0; r < PP; r++) begin : g_level0
        assign row[0][r] = pp[r*P +: P];
    end

    // ####################################################################
    // carry-save reduction
    // ####################################################################

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int N = rows_at(PP, l);
        localparam int G = N / 3;

        for (genvar g = 0; g < G; g++) begin : g_csa
            logic [P-1:0] a;
            logic [P-1:0] b;
            logic [P-1:0] c;
            logic [P-1:0] maj;

            assign a   = row[l][3*g];
            assign b   = row[l][3*g+1];
            assign c   = row[l][3*g+2];
            assign maj = (a & b) | (b & c) | (a & c);

            assign row[l+1][2*g]   = a ^ b ^ c;
            assign row[l+1][2*g+1] = maj << 1;  // carry weighs one bit more.
        end

        for (genvar k = 0; k < N - 3 * G; k++) begin : g_pass
            assign row[l+1][2*G+k] = row[l][3*G+k];
        end
    end

    // ####################################################################
    // final carry-propagate add
    // ####################################################################

    assign product = row[LEVELS][0] + row[LEVELS][1];

endmodule

// File: src/mul_unit.sv
module mul_unit #(
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    input  mul_types_pkg::mul_req_t  req,
    output mul_types_pkg::mul_rsp_t  rsp
);

    logic [WIDTH-1:0]       x_q;
    logic [WIDTH-1:0]       y_q;
    mul_types_pkg::mul_op_t op_q;
    logic                   en_q;
    logic                   status_q;
    logic                   ok;
    logic                   mul_signed;
    logic                   use_high;
    logic [2*WIDTH-1:0]     product;

    // ####################################################################
    // request register and sequencing
    // ####################################################################

    always_ff @(posedge clk) begin
        x_q  <= req.x;
        y_q  <= req.y;
        op_q <= req.op;
    end

    // status marks the second cycle of a pair while en is held high.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q     <= 1'b0;
            status_q <= 1'b0;
        end else begin
            en_q     <= en;
            status_q <= en & ok;  // cleared whenever en is low.
        end
    end

    assign ok = en_q & ~status_q;

    // ####################################################################
    // product and word select
    // ####################################################################

    assign mul_signed = (op_q == mul_types_pkg::MULH);  // MUL low word is sign free.
    assign use_high   = (op_q != mul_types_pkg::MUL);

    wallace_tree #(
        .WIDTH (WIDTH)
    ) u_tree (
        .x          (x_q),
        .y          (y_q),
        .mul_signed (mul_signed),
        .product    (product)
    );

    assign rsp.ok     = ok;
    assign rsp.result = use_high ? product[2*WIDTH-1:WIDTH] : product[WIDTH-1:0];

endmodule

// File: src/mul_top.sv
module mul_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    input  mul_types_pkg::mul_req_t  req,
    output mul_types_pkg::mul_rsp_t  rsp
);

    // ####################################################################
    // multiply unit sized to the architectural register width
    // ####################################################################

    localparam int WIDTH = mul_types_pkg::XLEN;

    mul_unit #(
        .WIDTH (WIDTH)
    ) u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .req   (req),
        .rsp   (rsp)
    );

endmodule

// File: bench/tb_mul_top.sv
module tb_mul_top;

    localparam CASE_FILE   = "bench/mul_cases.txt";
    localparam int BURST    = 6;   // trailing cases of the file that keep en high.
    localparam int CLK_HALF = 20;

    logic                    clk;
    logic                    rst_n;
    logic                    en;
    mul_types_pkg::mul_req_t req;
    mul_types_pkg::mul_rsp_t rsp;

    mul_types_pkg::mul_op_t         case_op  [$];
    logic [mul_types_pkg::XLEN-1:0] case_x   [$];
    logic [mul_types_pkg::XLEN-1:0] case_y   [$];
    logic [mul_types_pkg::XLEN-1:0] case_exp [$];

    int          n_cases;
    int          errors;
    int          checks;
    int          cycle_count;
    int          max_cycles;
    int unsigned seed_val;

    mul_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .req   (req),
        .rsp   (rsp)
    );

    // ####################################################################
    // clock and run limit
    // ####################################################################

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("timeout after %0d clock cycles, mul_ok did not arrive in time",
                     cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ####################################################################
    // helpers
    // ####################################################################

    function automatic string op_text(input mul_types_pkg::mul_op_t op);
        string s;
        case (op)
            mul_types_pkg::MUL:   s = "MUL";
            mul_types_pkg::MULH:  s = "MULH";
            mul_types_pkg::MULHU: s = "MULHU";
            default:              s = "???";
        endcase
        return s;
    endfunction

    task automatic load_cases();
        int          fd;
        int          got;
        int          count;
        int          line_no;
        string       line;
        logic [31:0] op_raw;
        logic [31:0] x_val;
        logic [31:0] y_val;
        logic [31:0] exp_val;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the case file %s", CASE_FILE);
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                got     = $fgets(line, fd);
                line_no = line_no + 1;
                count   = $sscanf(line, "%h %h %h %h", op_raw, x_val, y_val, exp_val);
                if (got > 0 && count == 4) begin  // comment lines give no fields.
                    if (op_raw > 2) begin
                        $display("case file line %0d holds an unknown opcode %0h",
                                 line_no, op_raw);
                        errors = errors + 1;
                    end else begin
                        case_op.push_back(mul_types_pkg::mul_op_t'(op_raw[1:0]));
                        case_x.push_back(x_val);
                        case_y.push_back(y_val);
                        case_exp.push_back(exp_val);
                    end
                end
            end
            $fclose(fd);
        end
        n_cases    = case_x.size();
        max_cycles = n_cases * 8 + 20;
    endtask

    task automatic check_idle(input string where);
        checks = checks + 1;
        assert (rsp.ok === 1'b0) else begin
            $display("Fail at time %0t: rsp.ok is high during %s", $time, where);
            errors = errors + 1;
        end
    endtask

    task automatic apply_reset();
        int i;
        int errors_before;
        errors_before = errors;
        rst_n = 1'b0;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_idle("reset");
        end
        rst_n = 1'b1;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            check_idle("the idle cycles after reset");
        end
        $display("reset and idle: %s", (errors == errors_before) ? "ok stayed low" : "errors");
    endtask

    // ####################################################################
    // one request and its response
    // ####################################################################

    task automatic run_one(input int k, input bit held);
        int latency;
        int want_latency;
        bit bad;
        req.op       = case_op[k];
        req.x        = case_x[k];
        req.y        = case_y[k];
        en           = 1'b1;
        want_latency = held ? 2 : 1;  // with en held the status bit skips a cycle.
        latency      = 0;
        bad          = 1'b0;
        do begin
            @(negedge clk);
            latency = latency + 1;
        end while (rsp.ok !== 1'b1);
        checks = checks + 2;
        assert (rsp.result === case_exp[k]) else begin
            $display("Fail at time %0t: case %0d %s x=%h y=%h gave %h, expected %h",
                     $time, k, op_text(case_op[k]), case_x[k], case_y[k],
                     rsp.result, case_exp[k]);
            errors = errors + 1;
            bad    = 1'b1;
        end
        assert (latency == want_latency) else begin
            $display("Fail at time %0t: case %0d mul_ok came after %0d cycles, expected %0d",
                     $time, k, latency, want_latency);
            errors = errors + 1;
            bad    = 1'b1;
        end
        $display("case %0d %-5s x=%h y=%h result=%h latency=%0d %s", k,
                 op_text(case_op[k]), case_x[k], case_y[k], rsp.result, latency,
                 bad ? "with errors" : "done");
    endtask

    task automatic run_cases();
        int k;
        int i;
        int gap;
        bit held;
        held = 1'b0;
        for (k = 0; k < n_cases; k++) begin
            run_one(k, held);
            if (k < n_cases - 1) begin
                if (k >= n_cases - BURST) begin
                    gap = 0;  // next request follows in the cycle ok was seen.
                end else begin
                    gap = $urandom % 4;
                end
                held = (gap == 0);
                if (gap > 0) begin
                    en = 1'b0;
                    for (i = 0; i < gap; i++) begin
                        @(negedge clk);
                        check_idle("an idle gap");
                    end
                end
            end
        end
        en = 1'b0;
        for (i = 0; i < 2; i++) begin
            @(negedge clk);
            check_idle("the idle cycles after the last case");
        end
    endtask

    // ####################################################################
    // main sequence
    // ####################################################################

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        en          = 1'b0;
        req         = '0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        max_cycles  = 20;
        seed_val    = $urandom(32'h98e6_78ce);
        load_cases();
        if (n_cases == 0) begin
            $display("no test cases could be read from %s", CASE_FILE);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            apply_reset();
            run_cases();
            $display("cases %0d, checks %0d, errors %0d", n_cases, checks, errors);
            if (errors == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

// File: sources.f
src/mul_types_pkg.sv
src/mul_arith_pkg.sv
src/booth_radix4.sv
src/wallace_tree.sv
src/mul_unit.sv
src/mul_top.sv
bench/tb_mul_top.sv

// File: Bender.yml
package:
  name: mul_unit

sources:
  # packages come first, the RTL follows in dependency order.
  - src/mul_types_pkg.sv
  - src/mul_arith_pkg.sv
  - src/booth_radix4.sv
  - src/wallace_tree.sv
  - src/mul_unit.sv
  - src/mul_top.sv

  - target: test
    files:
      - bench/tb_mul_top.sv

// File: bench/mul_cases.txt
# op x y expected, all in hex. op is 0 for MUL, 1 for MULH and 2 for MULHU.
# expected is the 32-bit result. The last six lines run back to back with en held high.
# MUL
0 00000000 00000000 00000000
0 00000003 00000007 00000015
0 0000ffff 0000ffff fffe0001
0 12345678 00000010 23456780
0 ffffffff ffffffff 00000001
0 fffffffe 00000005 fffffff6
0 80000000 80000000 00000000
0 80000000 ffffffff 80000000
0 7fffffff 7fffffff 00000001
0 12345678 9abcdef0 242d2080
0 cafebabe deadbeef 88cf5b62
0 00000003 fffffff9 ffffffeb
# MULH
1 80000000 80000000 40000000
1 80000000 ffffffff 00000000
1 fffffffe 00000005 ffffffff
1 ffffffff ffffffff 00000000
1 80000000 00000001 ffffffff
1 ffff0000 00010000 ffffffff
1 00000003 fffffff9 ffffffff
1 7fffffff 7fffffff 3fffffff
1 12345678 9abcdef0 f8cc93d6
1 cafebabe deadbeef 06e631ce
1 12345678 00000010 00000001
# MULHU
2 80000000 80000000 40000000
2 80000000 ffffffff 7fffffff
2 fffffffe 00000005 00000004
2 ffffffff ffffffff fffffffe
2 80000000 00000001 00000000
2 ffff0000 00010000 0000ffff
2 00000003 fffffff9 00000002
2 7fffffff 7fffffff 3fffffff
2 12345678 9abcdef0 0b00ea4e
2 cafebabe deadbeef b092ab7b
2 0000ffff 0000ffff 00000000
# back to back
0 cafebabe deadbeef 88cf5b62
1 12345678 9abcdef0 f8cc93d6
2 ffffffff ffffffff fffffffe
1 fffffffe 00000005 ffffffff
0 0000ffff 0000ffff fffe0001
2 12345678 9abcdef0 0b00ea4e
